// ==== src/ctrl_settings.svh ====
`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

`default_nettype none

// Instruction word and field layout
`define INSTR_W 32
`define OPCODE_W 6
`define FUNCT_W 6
`define OPCODE_LSB 26
`define FUNCT_LSB 0

// Control-side widths
`define ALUCTL_W 5
`define BYTEEN_W 4
`define STATE_W 3
`define EXECLEN_W 2

`default_nettype wire

`endif

// ==== src/isaPkg.sv ====
`include "ctrl_settings.svh"
`default_nettype none

package isaPkg;

  // Supported opcodes
  typedef enum logic [`OPCODE_W-1:0] {
    R_TYPE = 6'b000000,
    J      = 6'b000010,
    JAL    = 6'b000011,
    BEQ    = 6'b000100,
    BNE    = 6'b000101,
    BLEZ   = 6'b000110,
    BGTZ   = 6'b000111,
    ADDIU  = 6'b001001,
    SLTI   = 6'b001010,
    ANDI   = 6'b001100,
    ORI    = 6'b001101,
    XORI   = 6'b001110,
    LUI    = 6'b001111,
    LB     = 6'b100000,
    LH     = 6'b100001,
    LW     = 6'b100011,
    LBU    = 6'b100100,
    LHU    = 6'b100101,
    SW     = 6'b101011
  } opcode_t;

  // R-type funct codes
  typedef enum logic [`FUNCT_W-1:0] {
    JR   = 6'b001000,
    ADDU = 6'b100001,
    AND  = 6'b100100,
    OR   = 6'b100101
  } funct_t;

  typedef enum logic [3:0] {
    ALU_REG,
    ALU_IMM,
    LUI_IMM,
    LOAD,
    STORE,
    BRANCH,
    JUMP,
    JUMP_LINK,
    JUMP_REG,
    NOP_ILLEGAL
  } instrClass_t;

  typedef enum logic [2:0] {
    COND_EQ,
    COND_NE,
    COND_GTZ,
    COND_LEZ,
    COND_ALWAYS,
    COND_NEVER
  } branchCond_t;

  typedef enum logic [2:0] {
    WORD,
    HALF_S,
    HALF_U,
    BYTE_S,
    BYTE_U
  } loadKind_t;

  // Execute steps of one instruction, 1 to 3
  typedef logic [`EXECLEN_W-1:0] execLen_t;

endpackage

`default_nettype wire

// ==== src/ctrlPkg.sv ====
`include "ctrl_settings.svh"
`default_nettype none

package ctrlPkg;

  typedef enum logic [`STATE_W-1:0] {
    FETCH  = 3'b000,
    DECODE = 3'b001,
    EXEC_1 = 3'b010,
    EXEC_2 = 3'b011,
    EXEC_3 = 3'b100,
    HALTED = 3'b101,
    STALL  = 3'b110
  } state_t;

  // ALU control codes understood by the datapath ALU
  typedef enum logic [`ALUCTL_W-1:0] {
    OP_AND       = 5'd0,
    OP_OR        = 5'd1,
    OP_ADD       = 5'd2,
    OP_XOR       = 5'd3,
    OP_SLT       = 5'd7,
    OP_EQ        = 5'd10,
    OP_PASS_B    = 5'd11,
    OP_BR_TARGET = 5'd13,
    OP_PASS_A    = 5'd14,
    OP_FUNCT     = 5'd15,
    OP_LEZ       = 5'd16,
    OP_JUMP      = 5'd17,
    OP_LUI       = 5'd20
  } aluOp_t;

  typedef enum logic [1:0] {
    SRCB_REG        = 2'b00,
    SRCB_FOUR       = 2'b01,
    SRCB_IMM        = 2'b10,
    SRCB_BRANCH_OFS = 2'b11
  } srcB_t;

  // Load data extension applied by the memory path
  typedef enum logic [1:0] {
    EXT_NONE   = 2'b00,
    EXT_BYTE_S = 2'b10,
    EXT_HALF_S = 2'b11
  } memExt_t;

  localparam logic [`BYTEEN_W-1:0] BE_WORD = 4'b1111;
  localparam logic [`BYTEEN_W-1:0] BE_HALF = 4'b0011;
  localparam logic [`BYTEEN_W-1:0] BE_BYTE = 4'b0001;

endpackage

`default_nettype wire

// ==== src/instrDecode.sv ====
`timescale 1ns/1ps
`include "ctrl_settings.svh"
`default_nettype none

module instrDecode (
  input  wire logic [`INSTR_W-1:0] instr,
  output isaPkg::instrClass_t      instrClass,
  output ctrlPkg::aluOp_t          aluOp,
  output isaPkg::branchCond_t      branchCond,
  output isaPkg::loadKind_t        loadKind,
  output isaPkg::execLen_t         execLen,
  output logic                     zeroExtImm,
  output logic                     isLink
);

  logic [`OPCODE_W-1:0] opcode;
  logic [`FUNCT_W-1:0]  funct;

  assign opcode = instr[`OPCODE_LSB +: `OPCODE_W];
  assign funct  = instr[`FUNCT_LSB +: `FUNCT_W];

  // Class, ALU operation and branch rule
  always_comb begin
    instrClass = isaPkg::NOP_ILLEGAL;
    aluOp      = ctrlPkg::OP_ADD;
    branchCond = isaPkg::COND_NEVER;
    case (opcode)
      isaPkg::R_TYPE: begin
        if (funct == isaPkg::JR) begin
          instrClass = isaPkg::JUMP_REG;
          aluOp      = ctrlPkg::OP_PASS_A;
          branchCond = isaPkg::COND_ALWAYS;
        end else begin
          instrClass = isaPkg::ALU_REG;
          aluOp      = ctrlPkg::OP_FUNCT;
        end
      end
      isaPkg::ADDIU: instrClass = isaPkg::ALU_IMM;
      isaPkg::ANDI: begin
        instrClass = isaPkg::ALU_IMM;
        aluOp      = ctrlPkg::OP_AND;
      end
      isaPkg::ORI: begin
        instrClass = isaPkg::ALU_IMM;
        aluOp      = ctrlPkg::OP_OR;
      end
      isaPkg::XORI: begin
        instrClass = isaPkg::ALU_IMM;
        aluOp      = ctrlPkg::OP_XOR;
      end
      isaPkg::SLTI: begin
        instrClass = isaPkg::ALU_IMM;
        aluOp      = ctrlPkg::OP_SLT;
      end
      isaPkg::LUI: begin
        instrClass = isaPkg::LUI_IMM;
        aluOp      = ctrlPkg::OP_LUI;
      end
      // Address is base plus offset
      isaPkg::LW, isaPkg::LH, isaPkg::LHU, isaPkg::LB, isaPkg::LBU:
        instrClass = isaPkg::LOAD;
      isaPkg::SW: instrClass = isaPkg::STORE;
      isaPkg::BEQ, isaPkg::BNE: begin
        instrClass = isaPkg::BRANCH;
        aluOp      = ctrlPkg::OP_EQ;
        branchCond = (opcode == isaPkg::BEQ) ? isaPkg::COND_EQ : isaPkg::COND_NE;
      end
      isaPkg::BGTZ, isaPkg::BLEZ: begin
        instrClass = isaPkg::BRANCH;
        aluOp      = ctrlPkg::OP_LEZ;
        branchCond = (opcode == isaPkg::BLEZ) ? isaPkg::COND_LEZ : isaPkg::COND_GTZ;
      end
      isaPkg::J, isaPkg::JAL: begin
        instrClass = (opcode == isaPkg::JAL) ? isaPkg::JUMP_LINK : isaPkg::JUMP;
        aluOp      = ctrlPkg::OP_JUMP;
        branchCond = isaPkg::COND_ALWAYS;
      end
      default: ;
    endcase
  end

  always_comb begin
    case (opcode)
      isaPkg::LH:  loadKind = isaPkg::HALF_S;
      isaPkg::LHU: loadKind = isaPkg::HALF_U;
      isaPkg::LB:  loadKind = isaPkg::BYTE_S;
      isaPkg::LBU: loadKind = isaPkg::BYTE_U;
      default:     loadKind = isaPkg::WORD;
    endcase
  end

  // Loads need a third step for the writeback of memory data
  always_comb begin
    case (instrClass)
      isaPkg::ALU_REG, isaPkg::ALU_IMM, isaPkg::LUI_IMM,
      isaPkg::STORE, isaPkg::JUMP_LINK: execLen = 2'd2;
      isaPkg::LOAD: execLen = 2'd3;
      default:      execLen = 2'd1;
    endcase
  end

  assign zeroExtImm = opcode inside {isaPkg::ANDI, isaPkg::ORI, isaPkg::XORI};
  assign isLink     = opcode == isaPkg::JAL;

endmodule

`default_nettype wire

// ==== src/stateSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module stateSequencer (
  input  wire logic             clk,
  input  wire logic             arstN,
  input  wire logic             start,
  input  wire logic             pcIs0,
  input  wire logic             stall,
  input  wire logic             waitRequest,
  input  wire isaPkg::execLen_t execLen,
  output ctrlPkg::state_t       state,
  output logic                  lastStep,
  output logic                  active
);

  ctrlPkg::state_t  stateNext;
  isaPkg::execLen_t stepNum;
  logic             finalStep;

  // Position of the current execute step, zero outside execute
  always_comb begin
    case (state)
      ctrlPkg::EXEC_1: stepNum = 2'd1;
      ctrlPkg::EXEC_2: stepNum = 2'd2;
      ctrlPkg::EXEC_3: stepNum = 2'd3;
      default:         stepNum = 2'd0;
    endcase
  end

  assign finalStep = stepNum >= execLen;
  assign active    = state != ctrlPkg::HALTED;

  always_comb begin
    stateNext = state;
    case (state)
      ctrlPkg::HALTED: begin
        if (start) begin
          stateNext = ctrlPkg::FETCH;
        end
      end
      ctrlPkg::FETCH, ctrlPkg::STALL:
        stateNext = waitRequest ? ctrlPkg::STALL : ctrlPkg::DECODE;
      ctrlPkg::DECODE: stateNext = ctrlPkg::EXEC_1;
      ctrlPkg::EXEC_1: begin
        if (!stall) begin
          stateNext = finalStep ? ctrlPkg::FETCH : ctrlPkg::EXEC_2;
        end
      end
      ctrlPkg::EXEC_2: begin
        if (!waitRequest) begin
          stateNext = finalStep ? ctrlPkg::FETCH : ctrlPkg::EXEC_3;
        end
      end
      ctrlPkg::EXEC_3: stateNext = ctrlPkg::FETCH;
      default:         stateNext = ctrlPkg::HALTED;
    endcase
    // PC of zero ends the program
    if (pcIs0 && active) begin
      stateNext = ctrlPkg::HALTED;
    end
  end

  assign lastStep = (stepNum != 2'd0) && (stateNext == ctrlPkg::FETCH);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= ctrlPkg::HALTED;
    end else begin
      state <= stateNext;
    end
  end

  stateLegal: assert property (@(posedge clk) disable iff (!arstN)
    state inside {ctrlPkg::FETCH, ctrlPkg::DECODE, ctrlPkg::EXEC_1, ctrlPkg::EXEC_2,
                  ctrlPkg::EXEC_3, ctrlPkg::HALTED, ctrlPkg::STALL});

  // Memory wait stretches the access step
  memWaitHolds: assert property (@(posedge clk) disable iff (!arstN)
    (state == ctrlPkg::EXEC_2) && waitRequest && !pcIs0 |=> state == ctrlPkg::EXEC_2);

endmodule

`default_nettype wire

// ==== src/controlGen.sv ====
`timescale 1ns/1ps
`include "ctrl_settings.svh"
`default_nettype none

module controlGen (
  input  wire ctrlPkg::state_t     state,
  input  wire isaPkg::instrClass_t instrClass,
  input  wire ctrlPkg::aluOp_t     aluOp,
  input  wire isaPkg::loadKind_t   loadKind,
  input  wire logic                zeroExtImm,
  input  wire logic                branchDelay,
  output logic                     irWrite,
  output logic                     irSel,
  output logic                     pcWrite,
  output logic                     iOrD,
  output logic                     aluSrcA,
  output ctrlPkg::srcB_t           aluSrcB,
  output ctrlPkg::aluOp_t          aluControl,
  output logic                     aluSel,
  output logic                     extSel,
  output logic                     memRead,
  output logic                     memWrite,
  output logic [`BYTEEN_W-1:0]     byteEnable,
  output ctrlPkg::memExt_t         extendedMem,
  output logic                     isJump
);

  logic [`BYTEEN_W-1:0] loadBytes;
  ctrlPkg::memExt_t     loadExt;
  logic                 jumpTarget;

  always_comb begin
    case (loadKind)
      isaPkg::HALF_S, isaPkg::HALF_U: loadBytes = ctrlPkg::BE_HALF;
      isaPkg::BYTE_S, isaPkg::BYTE_U: loadBytes = ctrlPkg::BE_BYTE;
      default:                        loadBytes = ctrlPkg::BE_WORD;
    endcase
    case (loadKind)
      isaPkg::HALF_S: loadExt = ctrlPkg::EXT_HALF_S;
      isaPkg::BYTE_S: loadExt = ctrlPkg::EXT_BYTE_S;
      default:        loadExt = ctrlPkg::EXT_NONE;
    endcase
  end

  assign jumpTarget = instrClass inside {isaPkg::JUMP, isaPkg::JUMP_LINK};

  assign irWrite  = state == ctrlPkg::DECODE;
  assign irSel    = state != ctrlPkg::DECODE;
  assign pcWrite  = state == ctrlPkg::FETCH;
  assign memRead  = (state inside {ctrlPkg::FETCH, ctrlPkg::STALL}) ||
                    (state == ctrlPkg::EXEC_2 && instrClass == isaPkg::LOAD);
  assign memWrite = state == ctrlPkg::EXEC_2 && instrClass == isaPkg::STORE;
  assign isJump   = (state == ctrlPkg::EXEC_1 && instrClass == isaPkg::JUMP) ||
                    (state == ctrlPkg::EXEC_2 && instrClass == isaPkg::JUMP_LINK);

  // Default operation is PC plus 4 straight from the ALU
  always_comb begin
    iOrD        = 1'b0;
    aluSrcA     = 1'b0;
    aluSrcB     = ctrlPkg::SRCB_FOUR;
    aluControl  = ctrlPkg::OP_ADD;
    aluSel      = 1'b0;
    extSel      = 1'b0;
    byteEnable  = ctrlPkg::BE_WORD;
    extendedMem = ctrlPkg::EXT_NONE;
    case (state)
      // Taken branch fetches from the target held in the ALU register
      ctrlPkg::FETCH: aluSel = branchDelay;
      ctrlPkg::DECODE: begin
        aluSrcB = ctrlPkg::SRCB_BRANCH_OFS;
        if (jumpTarget) begin
          extSel     = 1'b1;
          aluControl = ctrlPkg::OP_PASS_B;
        end else begin
          aluControl = ctrlPkg::OP_BR_TARGET;
        end
      end
      ctrlPkg::EXEC_1: begin
        case (instrClass)
          isaPkg::ALU_REG, isaPkg::BRANCH: begin
            aluSrcA    = 1'b1;
            aluSrcB    = ctrlPkg::SRCB_REG;
            aluControl = aluOp;
            aluSel     = instrClass == isaPkg::BRANCH;
          end
          isaPkg::ALU_IMM, isaPkg::LUI_IMM, isaPkg::LOAD, isaPkg::STORE: begin
            aluSrcA    = 1'b1;
            aluSrcB    = ctrlPkg::SRCB_IMM;
            extSel     = zeroExtImm;
            aluControl = aluOp;
          end
          isaPkg::JUMP: begin
            aluSrcB    = ctrlPkg::SRCB_BRANCH_OFS;
            extSel     = 1'b1;
            aluControl = aluOp;
          end
          isaPkg::JUMP_REG: begin
            aluSrcA    = 1'b1;
            aluControl = aluOp;
          end
          // JAL return address is PC plus 4
          default: ;
        endcase
      end
      ctrlPkg::EXEC_2: begin
        case (instrClass)
          isaPkg::ALU_REG, isaPkg::ALU_IMM, isaPkg::LUI_IMM: aluSel = 1'b1;
          isaPkg::LOAD, isaPkg::STORE: begin
            iOrD   = 1'b1;
            aluSel = 1'b1;
            if (instrClass == isaPkg::LOAD) begin
              byteEnable  = loadBytes;
              extendedMem = loadExt;
            end
          end
          isaPkg::JUMP_LINK: begin
            aluSrcB    = ctrlPkg::SRCB_BRANCH_OFS;
            extSel     = 1'b1;
            aluControl = aluOp;
          end
          default: ;
        endcase
      end
      ctrlPkg::EXEC_3: begin
        if (instrClass == isaPkg::LOAD) begin
          byteEnable  = loadBytes;
          extendedMem = loadExt;
        end
      end
      default: ;
    endcase
  end

  always_comb begin
    memExclusive: assert final (!(memRead && memWrite));
  end

endmodule

`default_nettype wire

// ==== src/writebackCtrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module writebackCtrl (
  input  wire ctrlPkg::state_t     state,
  input  wire isaPkg::instrClass_t instrClass,
  input  wire logic                isLink,
  input  wire logic                lastStep,
  output logic                     regWrite,
  output logic                     regDst,
  output logic                     memToReg,
  output logic                     link
);

  logic writesResult;

  assign writesResult = instrClass inside {isaPkg::ALU_REG, isaPkg::ALU_IMM,
                                           isaPkg::LUI_IMM, isaPkg::LOAD};

  // JAL stores the return address in its first step
  assign link     = isLink && (state == ctrlPkg::EXEC_1);
  assign regWrite = (lastStep && writesResult) || link;

  // rd for R-type, rt otherwise
  assign regDst   = instrClass == isaPkg::ALU_REG;
  assign memToReg = instrClass != isaPkg::LOAD;

  always_comb begin
    writeInExec: assert final (!regWrite ||
      (state inside {ctrlPkg::EXEC_1, ctrlPkg::EXEC_2, ctrlPkg::EXEC_3}));
  end

endmodule

`default_nettype wire

// ==== src/branchResolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchResolve (
  input  wire logic                clk,
  input  wire logic                arstN,
  input  wire isaPkg::branchCond_t branchCond,
  input  wire logic                outLsb,
  input  wire logic                lastStep,
  input  wire ctrlPkg::state_t     state,
  output logic                     branchDelay,
  output logic                     pcSrc
);

  logic taken;

  // outLsb is the compare result of the ALU
  always_comb begin
    case (branchCond)
      isaPkg::COND_EQ:     taken = outLsb;
      isaPkg::COND_NE:     taken = !outLsb;
      isaPkg::COND_GTZ:    taken = !outLsb;
      isaPkg::COND_LEZ:    taken = outLsb;
      isaPkg::COND_ALWAYS: taken = 1'b1;
      default:             taken = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      branchDelay <= 1'b0;
    end else if (lastStep) begin
      branchDelay <= taken;
    end
  end

  assign pcSrc = branchDelay && (state == ctrlPkg::FETCH);

endmodule

`default_nettype wire

// ==== src/mipsControl.sv ====
`timescale 1ns/1ps
`include "ctrl_settings.svh"
`default_nettype none

module mipsControl (
  input  wire logic                clk,
  input  wire logic                arstN,
  input  wire logic [`INSTR_W-1:0] instr,
  input  wire logic                start,
  input  wire logic                pcIs0,
  input  wire logic                stall,
  input  wire logic                waitRequest,
  input  wire logic                outLsb,
  output logic                     irWrite,
  output logic                     irSel,
  output logic                     pcWrite,
  output logic                     iOrD,
  output logic                     aluSrcA,
  output ctrlPkg::srcB_t           aluSrcB,
  output ctrlPkg::aluOp_t          aluControl,
  output logic                     aluSel,
  output logic                     extSel,
  output logic                     memRead,
  output logic                     memWrite,
  output logic [`BYTEEN_W-1:0]     byteEnable,
  output ctrlPkg::memExt_t         extendedMem,
  output logic                     isJump,
  output logic                     regWrite,
  output logic                     regDst,
  output logic                     memToReg,
  output logic                     link,
  output logic                     branchDelay,
  output logic                     pcSrc,
  output ctrlPkg::state_t          state,
  output logic                     active
);

  // Decoded attributes of the held instruction
  isaPkg::instrClass_t instrClass;
  ctrlPkg::aluOp_t     aluOp;
  isaPkg::branchCond_t branchCond;
  isaPkg::loadKind_t   loadKind;
  isaPkg::execLen_t    execLen;
  logic                zeroExtImm;
  logic                isLink;
  logic                lastStep;

  instrDecode DECODE_U (
    .instr, .instrClass, .aluOp, .branchCond,
    .loadKind, .execLen, .zeroExtImm, .isLink
  );

  stateSequencer SEQ_U (
    .clk, .arstN, .start, .pcIs0, .stall, .waitRequest,
    .execLen, .state, .lastStep, .active
  );

  controlGen EXEC_U (
    .state, .instrClass, .aluOp, .loadKind, .zeroExtImm, .branchDelay,
    .irWrite, .irSel, .pcWrite, .iOrD, .aluSrcA, .aluSrcB, .aluControl,
    .aluSel, .extSel, .memRead, .memWrite, .byteEnable, .extendedMem, .isJump
  );

  writebackCtrl RESULT_U (
    .state, .instrClass, .isLink, .lastStep,
    .regWrite, .regDst, .memToReg, .link
  );

  branchResolve BRANCH_U (
    .clk, .arstN, .branchCond, .outLsb, .lastStep, .state,
    .branchDelay, .pcSrc
  );

endmodule

`default_nettype wire

// ==== verif/tbMipsControl.sv ====
`timescale 1ns/1ps
`include "ctrl_settings.svh"
`default_nettype none

module tbMipsControl;

  localparam int PERIOD    = 20;
  localparam int NUM_INSTR = 600;
  // Longest run of stall or waitRequest pulses
  localparam int MAX_HOLD  = 3;
  localparam int HALT_GAP  = 4;
  localparam int LIMIT_CYCLES = 16 + NUM_INSTR * (6 + 3 * MAX_HOLD + HALT_GAP);

  // Opcode mix, common ones listed twice, two unknown codes at the end
  localparam logic [5:0] OP_TABLE [32] = '{
    isaPkg::R_TYPE, isaPkg::R_TYPE, isaPkg::R_TYPE, isaPkg::R_TYPE,
    isaPkg::ADDIU, isaPkg::ADDIU, isaPkg::SLTI, isaPkg::ANDI,
    isaPkg::ORI, isaPkg::XORI, isaPkg::LUI, isaPkg::LB,
    isaPkg::LH, isaPkg::LW, isaPkg::LW, isaPkg::LBU,
    isaPkg::LHU, isaPkg::SW, isaPkg::SW, isaPkg::BEQ,
    isaPkg::BEQ, isaPkg::BNE, isaPkg::BNE, isaPkg::BLEZ,
    isaPkg::BGTZ, isaPkg::J, isaPkg::J, isaPkg::JAL,
    isaPkg::JAL, isaPkg::ORI, 6'b010000, 6'b111111
  };
  localparam logic [5:0] FUNCT_TABLE [4] = '{
    isaPkg::ADDU, isaPkg::AND, isaPkg::OR, isaPkg::JR
  };

  logic clk, arstN;
  logic [`INSTR_W-1:0] instr;
  logic start, pcIs0, stall, waitRequest, outLsb;

  logic irWrite, irSel, pcWrite, iOrD, aluSrcA, aluSel, extSel;
  logic memRead, memWrite, isJump, regWrite, regDst, memToReg, link;
  logic branchDelay, pcSrc, active;
  logic [`BYTEEN_W-1:0] byteEnable;
  ctrlPkg::srcB_t   aluSrcB;
  ctrlPkg::aluOp_t  aluControl;
  ctrlPkg::memExt_t extendedMem;
  ctrlPkg::state_t  state;

  // Reference model
  ctrlPkg::state_t     refState, refNext;
  isaPkg::instrClass_t refClass;
  logic [1:0]          refLen, refStep;
  logic                refHeld, refLast, refBd, expRegWrite, refJump;
  logic [5:0]          expLoad;

  // FETCH to FETCH cycle count of the DUT
  int   seqCycles, seqHeld, seqLen;
  logic seqValid;

  logic [31:0] lfsr;

  mipsControl DUT (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic takeBits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      v = {v[30:0], lfsr[0]};
    end
  endtask

  function automatic isaPkg::instrClass_t classOf(input logic [5:0] op, input logic [5:0] fn);
    case (op)
      isaPkg::R_TYPE: return (fn == isaPkg::JR) ? isaPkg::JUMP_REG : isaPkg::ALU_REG;
      isaPkg::ADDIU, isaPkg::SLTI, isaPkg::ANDI, isaPkg::ORI, isaPkg::XORI:
        return isaPkg::ALU_IMM;
      isaPkg::LUI: return isaPkg::LUI_IMM;
      isaPkg::LW, isaPkg::LH, isaPkg::LHU, isaPkg::LB, isaPkg::LBU: return isaPkg::LOAD;
      isaPkg::SW: return isaPkg::STORE;
      isaPkg::BEQ, isaPkg::BNE, isaPkg::BGTZ, isaPkg::BLEZ: return isaPkg::BRANCH;
      isaPkg::J: return isaPkg::JUMP;
      isaPkg::JAL: return isaPkg::JUMP_LINK;
      default: return isaPkg::NOP_ILLEGAL;
    endcase
  endfunction

  function automatic logic [1:0] lenOf(input isaPkg::instrClass_t cls);
    case (cls)
      isaPkg::ALU_REG, isaPkg::ALU_IMM, isaPkg::LUI_IMM, isaPkg::STORE, isaPkg::JUMP_LINK:
        return 2'd2;
      isaPkg::LOAD: return 2'd3;
      default: return 2'd1;
    endcase
  endfunction

  // Branch flag rule applied to the ALU compare bit
  function automatic logic takenOf(input logic [5:0] op, input logic [5:0] fn, input logic lsb);
    case (op)
      isaPkg::BEQ, isaPkg::BLEZ: return lsb;
      isaPkg::BNE, isaPkg::BGTZ: return !lsb;
      isaPkg::J, isaPkg::JAL: return 1'b1;
      isaPkg::R_TYPE: return fn == isaPkg::JR;
      default: return 1'b0;
    endcase
  endfunction

  // Byte enables then extension code
  function automatic logic [5:0] loadCtlOf(input logic [5:0] op);
    case (op)
      isaPkg::LH:  return {4'b0011, 2'b11};
      isaPkg::LHU: return {4'b0011, 2'b00};
      isaPkg::LB:  return {4'b0001, 2'b10};
      isaPkg::LBU: return {4'b0001, 2'b00};
      default:     return {4'b1111, 2'b00};
    endcase
  endfunction

  task automatic reportFail(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    $display("Fail %s expected 0x%0h actual 0x%0h", name, expVal, actVal);
    $display("sim failed");
    $fatal(1, "check error");
  endtask

  always_comb begin
    refClass = classOf(instr[`OPCODE_LSB +: `OPCODE_W], instr[`FUNCT_LSB +: `FUNCT_W]);
    refLen   = lenOf(refClass);
    refJump  = refClass inside {isaPkg::JUMP, isaPkg::JUMP_LINK};
    expLoad  = loadCtlOf(instr[`OPCODE_LSB +: `OPCODE_W]);
    refHeld  = (refState == ctrlPkg::EXEC_1 && stall) ||
               (refState == ctrlPkg::EXEC_2 && waitRequest);
    refNext  = refState;
    case (refState)
      ctrlPkg::HALTED: begin
        if (start) begin
          refNext = ctrlPkg::FETCH;
        end
      end
      ctrlPkg::FETCH, ctrlPkg::STALL:
        refNext = waitRequest ? ctrlPkg::STALL : ctrlPkg::DECODE;
      ctrlPkg::DECODE: refNext = ctrlPkg::EXEC_1;
      ctrlPkg::EXEC_1, ctrlPkg::EXEC_2, ctrlPkg::EXEC_3: begin
        if (!refHeld) begin
          if (refStep + 2'd1 == refLen) begin
            refNext = ctrlPkg::FETCH;
          end else if (refState == ctrlPkg::EXEC_1) begin
            refNext = ctrlPkg::EXEC_2;
          end else begin
            refNext = ctrlPkg::EXEC_3;
          end
        end
      end
      default: refNext = ctrlPkg::HALTED;
    endcase
    if (pcIs0 && refState != ctrlPkg::HALTED) begin
      refNext = ctrlPkg::HALTED;
    end
    refLast = (refState inside {ctrlPkg::EXEC_1, ctrlPkg::EXEC_2, ctrlPkg::EXEC_3}) &&
              refNext == ctrlPkg::FETCH;
    expRegWrite = (refLast && (refClass inside {isaPkg::ALU_REG, isaPkg::ALU_IMM,
                                                isaPkg::LUI_IMM, isaPkg::LOAD})) ||
                  (refState == ctrlPkg::EXEC_1 && refClass == isaPkg::JUMP_LINK);
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      refState <= ctrlPkg::HALTED;
      refStep  <= 2'd0;
      refBd    <= 1'b0;
    end else begin
      refState <= refNext;
      if (refState == ctrlPkg::DECODE) begin
        refStep <= 2'd0;
      end else if (refState inside {ctrlPkg::EXEC_1, ctrlPkg::EXEC_2} && !refHeld) begin
        refStep <= refStep + 2'd1;
      end
      if (refLast) begin
        refBd <= takenOf(instr[`OPCODE_LSB +: `OPCODE_W], instr[`FUNCT_LSB +: `FUNCT_W],
                         outLsb);
      end
    end
  end

  // A halt drops the instruction in flight from the count
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      seqCycles <= 0;
      seqHeld   <= 0;
      seqLen    <= 0;
      seqValid  <= 1'b0;
    end else if (state == ctrlPkg::FETCH) begin
      seqCycles <= 1;
      seqHeld   <= 0;
      seqValid  <= 1'b0;
    end else if (state == ctrlPkg::HALTED) begin
      seqValid <= 1'b0;
    end else begin
      seqCycles <= seqCycles + 1;
      if (state == ctrlPkg::STALL || (state == ctrlPkg::EXEC_1 && stall) ||
          (state == ctrlPkg::EXEC_2 && waitRequest)) begin
        seqHeld <= seqHeld + 1;
      end
      if (state == ctrlPkg::DECODE) begin
        seqValid <= 1'b1;
        seqLen   <= int'(refLen);
      end
    end
  end

  stateTrack: assert property (@(posedge clk) disable iff (!arstN) state == refState)
    else reportFail("stateTrack", 32'($sampled(refState)), 32'($sampled(state)));

  haltedQuiet: assert property (@(posedge clk) disable iff (!arstN)
    state == ctrlPkg::HALTED |->
      {active, memRead, memWrite, regWrite, pcWrite, irWrite} == 6'b000000)
    else reportFail("haltedQuiet", 32'd0, 32'($sampled({active, memRead, memWrite,
                                                        regWrite, pcWrite, irWrite})));

  startFetch: assert property (@(posedge clk) disable iff (!arstN)
    state == ctrlPkg::HALTED && start |=> state == ctrlPkg::FETCH)
    else reportFail("startFetch", 32'(ctrlPkg::FETCH), 32'($sampled(state)));

  pcHalt: assert property (@(posedge clk) disable iff (!arstN)
    state != ctrlPkg::HALTED && pcIs0 |=> state == ctrlPkg::HALTED)
    else reportFail("pcHalt", 32'(ctrlPkg::HALTED), 32'($sampled(state)));

  seqLength: assert property (@(posedge clk) disable iff (!arstN)
    state == ctrlPkg::FETCH && seqValid |-> seqCycles == 2 + seqLen + seqHeld)
    else reportFail("seqLength", $sampled(seqLen) + $sampled(seqHeld) + 2,
                    $sampled(seqCycles));

  // PC plus 4, or the stored target through the ALU bypass
  fetchCtl: assert property (@(posedge clk) disable iff (!arstN)
    state == ctrlPkg::FETCH |->
      {pcWrite, aluSel, aluSrcA, aluSrcB, aluControl} ==
      {1'b1, refBd, 1'b0, ctrlPkg::SRCB_FOUR, ctrlPkg::OP_ADD})
    else reportFail("fetchCtl",
                    32'({1'b1, $sampled(refBd), 1'b0, ctrlPkg::SRCB_FOUR, ctrlPkg::OP_ADD}),
                    32'($sampled({pcWrite, aluSel, aluSrcA, aluSrcB, aluControl})));

  decodeCtl: assert property (@(posedge clk) disable iff (!arstN)
    state == ctrlPkg::DECODE |->
      {irWrite, irSel, extSel, aluControl} ==
      {2'b10, refJump, refJump ? ctrlPkg::OP_PASS_B : ctrlPkg::OP_BR_TARGET})
    else reportFail("decodeCtl",
                    32'({2'b10, $sampled(refJump),
                         $sampled(refJump) ? ctrlPkg::OP_PASS_B : ctrlPkg::OP_BR_TARGET}),
                    32'($sampled({irWrite, irSel, extSel, aluControl})));

  jumpOk: assert property (@(posedge clk) disable iff (!arstN) isJump |-> refJump)
    else reportFail("jumpOk", 32'd1, 32'($sampled(refJump)));

  loadCtl: assert property (@(posedge clk) disable iff (!arstN)
    state == ctrlPkg::EXEC_2 && refClass == isaPkg::LOAD |->
      {memRead, memWrite, byteEnable, extendedMem} == {2'b10, expLoad})
    else reportFail("loadCtl", 32'({2'b10, $sampled(expLoad)}),
                    32'($sampled({memRead, memWrite, byteEnable, extendedMem})));

  storeCtl: assert property (@(posedge clk) disable iff (!arstN)
    state == ctrlPkg::EXEC_2 && refClass == isaPkg::STORE |->
      {memRead, memWrite, byteEnable} == 6'b011111)
    else reportFail("storeCtl", 32'h1f, 32'($sampled({memRead, memWrite, byteEnable})));

  // Data access takes its address from the ALU register
  dataAddr: assert property (@(posedge clk) disable iff (!arstN)
    state == ctrlPkg::EXEC_2 && refClass inside {isaPkg::LOAD, isaPkg::STORE} |-> iOrD)
    else reportFail("dataAddr", 32'd1, 32'($sampled(iOrD)));

  memExcl: assert property (@(posedge clk) disable iff (!arstN) !(memRead && memWrite))
    else reportFail("memExcl", 32'd0, 32'($sampled({memRead, memWrite})));

  branchFlag: assert property (@(posedge clk) disable iff (!arstN) branchDelay == refBd)
    else reportFail("branchFlag", 32'($sampled(refBd)), 32'($sampled(branchDelay)));

  pcSrcOk: assert property (@(posedge clk) disable iff (!arstN)
    pcSrc == (state == ctrlPkg::FETCH && refBd))
    else reportFail("pcSrcOk", 32'($sampled(state == ctrlPkg::FETCH && refBd)),
                    32'($sampled(pcSrc)));

  regWriteOk: assert property (@(posedge clk) disable iff (!arstN) regWrite == expRegWrite)
    else reportFail("regWriteOk", 32'($sampled(expRegWrite)), 32'($sampled(regWrite)));

  linkOk: assert property (@(posedge clk) disable iff (!arstN)
    link == (refState == ctrlPkg::EXEC_1 && refClass == isaPkg::JUMP_LINK))
    else reportFail("linkOk",
                    32'($sampled(refState == ctrlPkg::EXEC_1 &&
                                 refClass == isaPkg::JUMP_LINK)),
                    32'($sampled(link)));

  resultSel: assert property (@(posedge clk) disable iff (!arstN)
    {regDst, memToReg} == {refClass == isaPkg::ALU_REG, refClass != isaPkg::LOAD})
    else reportFail("resultSel",
                    32'($sampled({refClass == isaPkg::ALU_REG, refClass != isaPkg::LOAD})),
                    32'($sampled({regDst, memToReg})));

  initial begin : watchdog
    #(LIMIT_CYCLES * PERIOD);
    $display("Watchdog expired before all instructions ran");
    $display("sim failed");
    $fatal(1, "timeout");
  end

  initial begin : stimulus
    logic [31:0] r;
    logic [1:0] fSel;
    logic [5:0] op;
    logic [`INSTR_W-1:0] nInstr;
    logic nStart, nPc, nStall, nWait, nLsb;
    int instrCount, waitRun, stallRun, haltRun;
    lfsr        = 32'h5faec6e8;
    instrCount  = 0;
    waitRun     = 0;
    stallRun    = 0;
    haltRun     = 0;
    arstN       = 1'b0;
    instr       = '0;
    start       = 1'b0;
    pcIs0       = 1'b0;
    stall       = 1'b0;
    waitRequest = 1'b0;
    outLsb      = 1'b0;
    repeat (16) @(posedge clk);
    arstN <= 1'b1;
    while (instrCount < NUM_INSTR) begin
      // Decide on the stable mid-cycle state, apply on the next rising edge
      @(negedge clk);
      nInstr = instr;
      if (state == ctrlPkg::FETCH) begin
        takeBits(5, r);
        op = OP_TABLE[r[4:0]];
        takeBits(2, r);
        fSel = r[1:0];
        takeBits(20, r);
        nInstr = {op, r[19:0], FUNCT_TABLE[fSel]};
        instrCount++;
      end
      takeBits(2, r);
      nWait = (r[1:0] == 2'b11) && (waitRun < MAX_HOLD);
      waitRun = nWait ? waitRun + 1 : 0;
      takeBits(2, r);
      nStall = (r[1:0] == 2'b11) && (stallRun < MAX_HOLD);
      stallRun = nStall ? stallRun + 1 : 0;
      takeBits(1, r);
      nLsb = r[0];
      haltRun = (state == ctrlPkg::HALTED) ? haltRun + 1 : 0;
      takeBits(3, r);
      nStart = (r[2:0] == 3'd0) || (haltRun >= HALT_GAP);
      takeBits(7, r);
      nPc = (r[6:0] == 7'd0) && (state != ctrlPkg::HALTED);
      @(posedge clk);
      instr       <= nInstr;
      start       <= nStart;
      pcIs0       <= nPc;
      stall       <= nStall;
      waitRequest <= nWait;
      outLsb      <= nLsb;
    end
    repeat (4) @(posedge clk);
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+src
src/isaPkg.sv
src/ctrlPkg.sv
src/instrDecode.sv
src/stateSequencer.sv
src/controlGen.sv
src/writebackCtrl.sv
src/branchResolve.sv
src/mipsControl.sv
verif/tbMipsControl.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f flist.f --top-module tbMipsControl \
  -Mdir obj_dir -o simv > build.log 2>&1 || { echo "build error, see build.log"; exit 1; }
./obj_dir/simv | tee sim.log
grep -q "sim failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "sim passed" sim.log || { echo "no result in sim.log"; exit 1; }
echo "PASS"
